// ==== common/tenyr_settings.svh ====
`ifndef TENYR_SETTINGS_SVH
`define TENYR_SETTINGS_SVH

`define TENYR_DATA_W 32
`define TENYR_ADDR_W 32

// words of shared program and data memory.
`define TENYR_MEM_DEPTH 1024

`define TENYR_REG_COUNT 16

`define TENYR_DISPLAY_ADDR 32'h100
`define TENYR_DISPLAY_W 16

`endif

// ==== common/tenyr_isa_pkg.sv ====
`default_nettype none
`include "tenyr_settings.svh"

package tenyr_isa_pkg;

    typedef logic [`TENYR_DATA_W-1:0] word_t;
    typedef logic [`TENYR_ADDR_W-1:0] addr_t;
    typedef logic [3:0] reg_idx_t;
    typedef logic [11:0] imm_t; // sign-extended when used.

    typedef enum logic [3:0] {
        kind_alu   = 4'd0,
        kind_load  = 4'd1,
        kind_store = 4'd2,
        kind_halt  = 4'd3
    } insn_kind_t;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_shl = 4'd5,
        op_shr = 4'd6,
        op_slt = 4'd7,
        op_eq  = 4'd8
    } alu_op_t;

    // Z <- X op Y + imm.
    typedef struct packed {
        insn_kind_t kind;
        reg_idx_t   z;
        reg_idx_t   x;
        reg_idx_t   y;
        alu_op_t    op;
        word_t      imm;
    } decoded_t;

endpackage

`default_nettype wire

// ==== common/tenyr_bus_pkg.sv ====
`default_nettype none

package tenyr_bus_pkg;

    typedef struct packed {
        logic                 valid; // one-cycle strobe.
        logic                 we;
        tenyr_isa_pkg::addr_t addr;
        tenyr_isa_pkg::word_t data;
    } bus_req_t;

    typedef struct packed {
        tenyr_isa_pkg::word_t x;
        tenyr_isa_pkg::word_t y;
    } operands_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_load,
        st_halted
    } core_state_t;

endpackage

`default_nettype wire

// ==== core/tenyr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module tenyr_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    decode_en,
    input  tenyr_isa_pkg::word_t    insn_data,
    output tenyr_isa_pkg::decoded_t decoded
);
    tenyr_isa_pkg::imm_t     imm;
    tenyr_isa_pkg::decoded_t next;

    assign imm = insn_data[11:0];

    always_comb begin
        case (insn_data[31:28])
            4'd0:    next.kind = tenyr_isa_pkg::kind_alu;
            4'd1:    next.kind = tenyr_isa_pkg::kind_load;
            4'd2:    next.kind = tenyr_isa_pkg::kind_store;
            default: next.kind = tenyr_isa_pkg::kind_halt; // unknown kinds stop the core.
        endcase
        next.z   = insn_data[27:24];
        next.x   = insn_data[23:20];
        next.y   = insn_data[19:16];
        next.op  = tenyr_isa_pkg::alu_op_t'(insn_data[15:12]);
        next.imm = {{($bits(tenyr_isa_pkg::word_t) - $bits(tenyr_isa_pkg::imm_t)){imm[11]}}, imm};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded      <= '0; // r0 <- r0 + r0 does nothing.
            decoded.kind <= tenyr_isa_pkg::kind_alu;
            decoded.op   <= tenyr_isa_pkg::op_add;
        end else if (decode_en) begin
            decoded <= next;
        end
    end

endmodule

`default_nettype wire

// ==== core/tenyr_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module tenyr_execute (
    input  tenyr_isa_pkg::decoded_t  decoded,
    input  tenyr_bus_pkg::operands_t operands,
    output tenyr_isa_pkg::word_t     alu_value,
    output tenyr_isa_pkg::addr_t     mem_addr
);
    localparam int SHAMT_W = $clog2($bits(tenyr_isa_pkg::word_t));

    tenyr_isa_pkg::word_t x;
    tenyr_isa_pkg::word_t y;
    tenyr_isa_pkg::word_t alu_raw;
    logic [SHAMT_W-1:0]   shamt;

    assign x     = operands.x;
    assign y     = operands.y;
    assign shamt = y[SHAMT_W-1:0];

    always_comb begin
        case (decoded.op)
            tenyr_isa_pkg::op_add: alu_raw = x + y;
            tenyr_isa_pkg::op_sub: alu_raw = x - y;
            tenyr_isa_pkg::op_and: alu_raw = x & y;
            tenyr_isa_pkg::op_or:  alu_raw = x | y;
            tenyr_isa_pkg::op_xor: alu_raw = x ^ y;
            tenyr_isa_pkg::op_shl: alu_raw = x << shamt;
            tenyr_isa_pkg::op_shr: alu_raw = x >> shamt; // logical shift.
            tenyr_isa_pkg::op_slt: alu_raw = tenyr_isa_pkg::word_t'($signed(x) < $signed(y));
            tenyr_isa_pkg::op_eq:  alu_raw = tenyr_isa_pkg::word_t'(x == y);
            default:               alu_raw = '0;
        endcase
    end

    assign alu_value = alu_raw + decoded.imm;

    // loads and stores address X + imm.
    assign mem_addr = tenyr_isa_pkg::addr_t'(x + decoded.imm);

endmodule

`default_nettype wire

// ==== core/tenyr_result.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tenyr_settings.svh"

module tenyr_result (
    input  logic                     clk,
    input  logic                     reset,
    input  tenyr_isa_pkg::decoded_t  decoded,
    input  tenyr_isa_pkg::word_t     alu_value,
    input  tenyr_isa_pkg::addr_t     mem_addr,
    input  tenyr_isa_pkg::word_t     load_data,
    output tenyr_isa_pkg::addr_t     fetch_addr,
    output logic                     decode_en,
    output tenyr_bus_pkg::operands_t operands,
    output tenyr_bus_pkg::bus_req_t  bus,
    output logic                     halt
);
    localparam tenyr_isa_pkg::reg_idx_t PC_REG =
        tenyr_isa_pkg::reg_idx_t'(`TENYR_REG_COUNT - 1);

    tenyr_bus_pkg::core_state_t state;
    tenyr_isa_pkg::addr_t       pc;
    tenyr_isa_pkg::word_t       regs [`TENYR_REG_COUNT];
    tenyr_isa_pkg::word_t       z_value;
    tenyr_isa_pkg::word_t       wb_value;
    logic                       in_execute;
    logic                       wb_en;
    logic                       pc_step;

    function automatic tenyr_isa_pkg::word_t read_reg(input tenyr_isa_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (idx == PC_REG) begin
            return pc; // r15 reads as the pc of this instruction.
        end
        return regs[idx];
    endfunction

    always_comb begin
        operands.x = read_reg(decoded.x);
        operands.y = read_reg(decoded.y);
        z_value    = read_reg(decoded.z);
    end

    assign in_execute = state == tenyr_bus_pkg::st_execute;
    assign wb_en      = (in_execute && decoded.kind == tenyr_isa_pkg::kind_alu) ||
                        state == tenyr_bus_pkg::st_load;
    assign wb_value   = (state == tenyr_bus_pkg::st_load) ? load_data : alu_value;
    assign pc_step    = wb_en || (in_execute && decoded.kind == tenyr_isa_pkg::kind_store);

    assign bus.valid = in_execute && (decoded.kind == tenyr_isa_pkg::kind_load ||
                                      decoded.kind == tenyr_isa_pkg::kind_store);
    assign bus.we    = decoded.kind == tenyr_isa_pkg::kind_store;
    assign bus.addr  = mem_addr;
    assign bus.data  = z_value;

    assign fetch_addr = pc;
    assign decode_en  = state == tenyr_bus_pkg::st_decode;
    assign halt       = state == tenyr_bus_pkg::st_halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= tenyr_bus_pkg::st_fetch;
            pc    <= '0;
        end else begin
            case (state)
                tenyr_bus_pkg::st_fetch:   state <= tenyr_bus_pkg::st_decode;
                tenyr_bus_pkg::st_decode:  state <= tenyr_bus_pkg::st_execute;
                tenyr_bus_pkg::st_execute: begin
                    case (decoded.kind)
                        tenyr_isa_pkg::kind_alu,
                        tenyr_isa_pkg::kind_store: state <= tenyr_bus_pkg::st_fetch;
                        tenyr_isa_pkg::kind_load:  state <= tenyr_bus_pkg::st_load;
                        default:                   state <= tenyr_bus_pkg::st_halted;
                    endcase
                end
                tenyr_bus_pkg::st_load:    state <= tenyr_bus_pkg::st_fetch;
                default:                   state <= tenyr_bus_pkg::st_halted;
            endcase
            if (pc_step) begin
                pc <= (wb_en && decoded.z == PC_REG) ? wb_value : pc + 1'b1; // r15 is a jump.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en && decoded.z != '0 && decoded.z != PC_REG) begin
            regs[decoded.z] <= wb_value;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tenyr_mem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tenyr_settings.svh"

module tenyr_mem (
    input  logic                    clk,
    input  tenyr_isa_pkg::addr_t    fetch_addr,
    output tenyr_isa_pkg::word_t    insn_data,
    input  tenyr_bus_pkg::bus_req_t bus,
    output tenyr_isa_pkg::word_t    rdata,
    input  logic                    load_en,
    input  tenyr_isa_pkg::addr_t    load_addr,
    input  tenyr_isa_pkg::word_t    load_data
);
    localparam int IDX_W = $clog2(`TENYR_MEM_DEPTH);
    localparam tenyr_isa_pkg::addr_t DEPTH = tenyr_isa_pkg::addr_t'(`TENYR_MEM_DEPTH);

    tenyr_isa_pkg::word_t mem [`TENYR_MEM_DEPTH];
    logic                 fetch_hit;
    logic                 bus_hit;
    logic                 load_hit;

    assign fetch_hit = fetch_addr < DEPTH;
    assign bus_hit   = bus.addr < DEPTH;
    assign load_hit  = load_en && load_addr < DEPTH;

    always_ff @(posedge clk) begin
        if (load_hit) begin
            mem[load_addr[IDX_W-1:0]] <= load_data; // load port has priority.
        end else if (bus.valid && bus.we && bus_hit) begin
            mem[bus.addr[IDX_W-1:0]] <= bus.data;
        end
        insn_data <= fetch_hit ? mem[fetch_addr[IDX_W-1:0]] : '0;
        rdata     <= bus_hit ? mem[bus.addr[IDX_W-1:0]] : '0; // zero outside memory.
    end

endmodule

`default_nettype wire

// ==== hdl/tenyr_mmr.sv ====
`timescale 1ns/100ps
`default_nettype none

module tenyr_mmr #(
    parameter tenyr_isa_pkg::addr_t ADDR  = '0,
    parameter int                   WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  tenyr_bus_pkg::bus_req_t bus,
    output logic [WIDTH-1:0]        value,
    output logic                    strobe
);
    logic hit;

    assign hit = bus.valid && bus.we && bus.addr == ADDR; // write-only register.

    always_ff @(posedge clk) begin
        if (reset) begin
            value  <= '0;
            strobe <= 1'b0;
        end else begin
            strobe <= hit;
            if (hit) begin
                value <= bus.data[WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tenyr_soc.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tenyr_settings.svh"

module tenyr_soc (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load_en,
    input  tenyr_isa_pkg::addr_t         load_addr,
    input  tenyr_isa_pkg::word_t         load_data,
    output logic [`TENYR_DISPLAY_W-1:0]  display,
    output logic                         display_strobe,
    output logic                         halt
);
    tenyr_isa_pkg::addr_t     fetch_addr;
    tenyr_isa_pkg::word_t     insn_data;
    tenyr_isa_pkg::decoded_t  decoded;
    tenyr_bus_pkg::operands_t operands;
    tenyr_isa_pkg::word_t     alu_value;
    tenyr_isa_pkg::addr_t     mem_addr;
    tenyr_bus_pkg::bus_req_t  bus;
    tenyr_isa_pkg::word_t     rdata;
    logic                     decode_en;

    tenyr_decode decode_i (
        .clk       (clk),
        .reset     (reset),
        .decode_en (decode_en),
        .insn_data (insn_data),
        .decoded   (decoded)
    );

    tenyr_execute execute_i (
        .decoded   (decoded),
        .operands  (operands),
        .alu_value (alu_value),
        .mem_addr  (mem_addr)
    );

    tenyr_result result_i (
        .clk        (clk),
        .reset      (reset),
        .decoded    (decoded),
        .alu_value  (alu_value),
        .mem_addr   (mem_addr),
        .load_data  (rdata),
        .fetch_addr (fetch_addr),
        .decode_en  (decode_en),
        .operands   (operands),
        .bus        (bus),
        .halt       (halt)
    );

    // instruction and operand ports share one array.
    tenyr_mem mem_i (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .insn_data  (insn_data),
        .bus        (bus),
        .rdata      (rdata),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    tenyr_mmr #(
        .ADDR  (`TENYR_DISPLAY_ADDR),
        .WIDTH (`TENYR_DISPLAY_W)
    ) display_i (
        .clk    (clk),
        .reset  (reset),
        .bus    (bus),
        .value  (display),
        .strobe (display_strobe)
    );

endmodule

`default_nettype wire

// ==== testbench/tenyr_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tenyr_settings.svh"

module tenyr_checker (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        exp_valid,
    input  logic [127:0]                exp_name,
    input  logic [`TENYR_DISPLAY_W-1:0] exp_value,
    input  logic [`TENYR_DISPLAY_W-1:0] display,
    input  logic                        display_strobe,
    input  logic                        halt,
    output int                          error_count,
    output int                          check_count,
    output int                          pending
);
    logic [127:0]                name_q [$];
    logic [`TENYR_DISPLAY_W-1:0] value_q [$];

    // expectations queue up in program order while memory is loaded.
    always @(posedge clk) begin
        if (exp_valid) begin
            name_q.push_back(exp_name);
            value_q.push_back(exp_value);
        end
        if (!reset && display_strobe) begin
            if (halt) begin
                $display("Display strobe seen after halt, display %h", display);
                error_count++;
            end
            if (value_q.size() == 0) begin
                $display("Display strobe with no expected value left, display %h", display);
                error_count++;
            end else begin
                check_count++;
                if (display !== value_q[0]) begin
                    $display("Mismatch in %0s: expected %h, actual %h",
                             name_q[0], value_q[0], display);
                    error_count++;
                end
                void'(name_q.pop_front());
                void'(value_q.pop_front());
            end
        end
        pending = value_q.size();
    end

endmodule

`default_nettype wire

// ==== testbench/tenyr_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module tenyr_assert (
    input logic                    clk,
    input logic                    reset,
    input logic                    display_strobe,
    input logic                    halt,
    input tenyr_bus_pkg::bus_req_t bus
);
    int fail_count = 0;

    strobe_single: assert property (@(posedge clk) disable iff (reset)
        display_strobe |=> !display_strobe)
        else begin
            $error("display_strobe high on two consecutive cycles");
            fail_count++;
        end

    // one reset edge is enough to leave st_halted.
    halt_after_reset: assert property (@(posedge clk) reset |=> !halt)
        else begin
            $error("halt high after a reset cycle");
            fail_count++;
        end

    quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
        halt |-> !bus.valid)
        else begin
            $error("bus valid high while halted");
            fail_count++;
        end

endmodule

bind tenyr_soc tenyr_assert assert_i (
    .clk            (clk),
    .reset          (reset),
    .display_strobe (display_strobe),
    .halt           (halt),
    .bus            (bus)
);

`default_nettype wire

// ==== testbench/tenyr_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tenyr_settings.svh"

module tenyr_tb;

    localparam int          RUN_TIMEOUT  = 2000; // cycles from reset release to halt.
    localparam int          QUIET_CYCLES = 50;
    localparam int          RESET_CYCLES = 8;
    localparam logic [11:0] DISPLAY_IMM  = 12'(`TENYR_DISPLAY_ADDR);

    typedef struct packed {
        logic [127:0]                name;
        tenyr_isa_pkg::word_t        insn;
        logic                        has_exp;
        logic [`TENYR_DISPLAY_W-1:0] exp;
    } step_t;

    logic                        clk;
    logic                        reset;
    logic                        load_en;
    tenyr_isa_pkg::addr_t        load_addr;
    tenyr_isa_pkg::word_t        load_data;
    logic [`TENYR_DISPLAY_W-1:0] display;
    logic                        display_strobe;
    logic                        halt;
    logic                        exp_valid;
    logic [127:0]                exp_name;
    logic [`TENYR_DISPLAY_W-1:0] exp_value;
    int                          check_errors;
    int                          check_count;
    int                          pending;
    int                          run_errors;
    int                          total_errors;
    step_t                       steps [$];

    tenyr_soc dut_i (
        .clk            (clk),
        .reset          (reset),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .display        (display),
        .display_strobe (display_strobe),
        .halt           (halt)
    );

    tenyr_checker check_i (
        .clk            (clk),
        .reset          (reset),
        .exp_valid      (exp_valid),
        .exp_name       (exp_name),
        .exp_value      (exp_value),
        .display        (display),
        .display_strobe (display_strobe),
        .halt           (halt),
        .error_count    (check_errors),
        .check_count    (check_count),
        .pending        (pending)
    );

    always #5 clk = ~clk;

    function automatic tenyr_isa_pkg::word_t alu_insn(input logic [3:0] z, input logic [3:0] x,
        input logic [3:0] y, input tenyr_isa_pkg::alu_op_t op, input logic [11:0] imm);
        return {tenyr_isa_pkg::kind_alu, z, x, y, op, imm};
    endfunction

    function automatic tenyr_isa_pkg::word_t store_insn(input logic [3:0] z, input logic [3:0] x,
        input logic [11:0] imm);
        return {tenyr_isa_pkg::kind_store, z, x, 8'd0, imm}; // stores Z at X + imm.
    endfunction

    function automatic tenyr_isa_pkg::word_t load_insn(input logic [3:0] z, input logic [3:0] x,
        input logic [11:0] imm);
        return {tenyr_isa_pkg::kind_load, z, x, 8'd0, imm};
    endfunction

    function automatic tenyr_isa_pkg::word_t halt_insn();
        return {tenyr_isa_pkg::kind_halt, 28'd0};
    endfunction

    task automatic add_step(input logic [127:0] name, input tenyr_isa_pkg::word_t insn);
        step_t s;
        s      = '0;
        s.name = name;
        s.insn = insn;
        steps.push_back(s);
    endtask

    task automatic add_display(input logic [127:0] name, input logic [3:0] z,
        input logic [`TENYR_DISPLAY_W-1:0] exp);
        step_t s;
        s         = '0;
        s.name    = name;
        s.insn    = store_insn(z, 4'd0, DISPLAY_IMM);
        s.has_exp = 1'b1;
        s.exp     = exp;
        steps.push_back(s);
    endtask

    // r1 = 5, r2 = 3, r4 = -1, r5 = 20.
    task automatic build_program();
        add_step("set_r1", alu_insn(4'd1, 4'd0, 4'd0, tenyr_isa_pkg::op_add, 12'h005));
        add_step("set_r2", alu_insn(4'd2, 4'd0, 4'd0, tenyr_isa_pkg::op_add, 12'h003));
        add_step("set_r4", alu_insn(4'd4, 4'd0, 4'd0, tenyr_isa_pkg::op_add, 12'hfff));
        add_step("set_r5", alu_insn(4'd5, 4'd0, 4'd0, tenyr_isa_pkg::op_add, 12'h014));
        add_step("add", alu_insn(4'd3, 4'd1, 4'd2, tenyr_isa_pkg::op_add, 12'h010));
        add_display("show_add", 4'd3, 16'h0018);
        add_step("sub", alu_insn(4'd3, 4'd1, 4'd2, tenyr_isa_pkg::op_sub, 12'h000));
        add_display("show_sub", 4'd3, 16'h0002);
        add_step("and", alu_insn(4'd3, 4'd1, 4'd2, tenyr_isa_pkg::op_and, 12'h000));
        add_display("show_and", 4'd3, 16'h0001);
        add_step("or", alu_insn(4'd3, 4'd1, 4'd2, tenyr_isa_pkg::op_or, 12'h100));
        add_display("show_or", 4'd3, 16'h0107);
        add_step("xor", alu_insn(4'd3, 4'd1, 4'd2, tenyr_isa_pkg::op_xor, 12'h000));
        add_display("show_xor", 4'd3, 16'h0006);
        add_step("shl", alu_insn(4'd3, 4'd1, 4'd2, tenyr_isa_pkg::op_shl, 12'h000));
        add_display("show_shl", 4'd3, 16'h0028);
        add_step("shr", alu_insn(4'd3, 4'd4, 4'd5, tenyr_isa_pkg::op_shr, 12'h000));
        add_display("show_shr", 4'd3, 16'h0fff); // zeros shift in from the top.
        add_step("slt", alu_insn(4'd3, 4'd4, 4'd1, tenyr_isa_pkg::op_slt, 12'h010));
        add_display("show_slt", 4'd3, 16'h0011); // signed compare.
        add_step("eq", alu_insn(4'd3, 4'd1, 4'd1, tenyr_isa_pkg::op_eq, 12'h040));
        add_display("show_eq", 4'd3, 16'h0041);
        add_step("write_r0", alu_insn(4'd0, 4'd1, 4'd2, tenyr_isa_pkg::op_add, 12'h055));
        add_display("show_r0", 4'd0, 16'h0000);
        add_step("set_r6", alu_insn(4'd6, 4'd0, 4'd0, tenyr_isa_pkg::op_add, 12'h5a5));
        add_step("store_mem", store_insn(4'd6, 4'd0, 12'h200));
        add_step("load_mem", load_insn(4'd7, 4'd0, 12'h200));
        add_display("show_load", 4'd7, 16'h05a5);
        add_step("set_r8", alu_insn(4'd8, 4'd0, 4'd0, tenyr_isa_pkg::op_add, 12'h7ad));
        add_step("jump", alu_insn(4'd15, 4'd15, 4'd0, tenyr_isa_pkg::op_add, 12'h002));
        add_step("skipped", store_insn(4'd8, 4'd0, DISPLAY_IMM)); // never shown.
        add_display("after_jump", 4'd1, 16'h0005);
        add_step("halt", halt_insn());
    endtask

    initial begin
        int cycles;
        clk        = 1'b0;
        reset      = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        exp_valid  = 1'b0;
        exp_name   = '0;
        exp_value  = '0;
        run_errors = 0;
        build_program();
        @(negedge clk);
        foreach (steps[i]) begin
            load_en   = 1'b1;
            load_addr = tenyr_isa_pkg::addr_t'(i);
            load_data = steps[i].insn;
            exp_valid = steps[i].has_exp;
            exp_name  = steps[i].name;
            exp_value = steps[i].exp;
            @(negedge clk);
        end
        load_en   = 1'b0;
        exp_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk); // reset holds through the load and 8 more.
        reset = 1'b0;
        cycles = 0;
        while (!halt && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("Timeout: halt did not rise within %0d cycles", RUN_TIMEOUT);
            run_errors++;
        end else begin
            for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
                @(negedge clk);
                if (!halt) begin
                    $display("Halt dropped after the core had halted");
                    run_errors++;
                end
            end
        end
        if (pending != 0) begin
            $display("%0d expected display values never appeared", pending);
            run_errors++;
        end
        total_errors = check_errors + run_errors + dut_i.assert_i.fail_count;
        $display("errors: %0d (checker %0d, assertions %0d, run %0d), display checks: %0d",
                 total_errors, check_errors, dut_i.assert_i.fail_count, run_errors,
                 check_count);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/tenyr_isa_pkg.sv
common/tenyr_bus_pkg.sv
core/tenyr_decode.sv
core/tenyr_execute.sv
core/tenyr_result.sv
hdl/tenyr_mem.sv
hdl/tenyr_mmr.sv
hdl/tenyr_soc.sv
testbench/tenyr_checker.sv
testbench/tenyr_assert.sv
testbench/tenyr_tb.sv

// ==== Makefile ====
TOP = tenyr_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f \
		-Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
